// File: bench/pcd_driver.sv
/*
 * reader side model that Miller-codes a frame onto pause_n on the falling clock edge
 * every pause lasts 2 cycles, Z at the slot start and X at the half slot
 * the last byte may be partial or cut before its parity bit, never both
 */
`timescale 1ns/1ns
`include "iso14443a_config.svh"

module pcd_driver (
    input  logic clk,
    output logic pause_n
);

    // quiet slots after each frame, enough for both decoders to go idle
    localparam int IDLE_SLOTS = 4;
    localparam int HALF_POS   = `RX_HALF_CLOCKS;

    // the field is on until the first frame starts
    initial begin
        pause_n <= 1'b1;
    end

    // ==============================
    // one bit slot
    // ==============================

    task automatic send_slot(input iso14443a_pkg::seq_t symbol);
        int pause_at;
        int c;

        // Y carries no pause at all
        if (symbol == iso14443a_pkg::SEQ_Z) begin
            pause_at = 0;
        end else if (symbol == iso14443a_pkg::SEQ_X) begin
            pause_at = HALF_POS;
        end else begin
            pause_at = -1;
        end
        for (c = 0; c < `RX_BIT_CLOCKS; c++) begin
            @(negedge clk);
            pause_n <= !((pause_at >= 0) && (c >= pause_at) && (c < pause_at + 2));
        end
    endtask

    // ==============================
    // whole frame
    // ==============================

    task automatic send_frame(
        input iso14443a_pkg::byte_t bytes[$],
        input int                   part_bits,
        input int                   flip_idx,
        input bit                   bad_zx,
        input bit                   trunc
    );
        logic                bits[$];
        iso14443a_pkg::seq_t symbols[$];
        logic                prev_zero;
        logic                par;
        int                  nbits;
        int                  i;
        int                  b;

        // bits go out least significant first, odd parity after each full byte
        for (i = 0; i < bytes.size(); i++) begin
            if ((i == bytes.size() - 1) && (part_bits != 0)) begin
                nbits = part_bits;
            end else begin
                nbits = 8;
            end
            for (b = 0; b < nbits; b++) begin
                bits.push_back(bytes[i][b]);
            end
            if ((nbits == 8) && !((i == bytes.size() - 1) && trunc)) begin
                par = ~(^bytes[i]);
                if (i == flip_idx) begin
                    par = ~par;
                end
                bits.push_back(par);
            end
        end

        // start of communication counts as a 0 for the coding of the next bit
        symbols.push_back(iso14443a_pkg::SEQ_Z);
        prev_zero = 1'b1;
        for (b = 0; b < bits.size(); b++) begin
            if (bits[b]) begin
                symbols.push_back(iso14443a_pkg::SEQ_X);
                prev_zero = 1'b0;
            end else begin
                if (prev_zero) begin
                    symbols.push_back(iso14443a_pkg::SEQ_Z);
                end else begin
                    symbols.push_back(iso14443a_pkg::SEQ_Y);
                end
                prev_zero = 1'b1;
            end
        end

        if (bad_zx) begin
            // a 1 and then a Z, which no valid reader sends
            symbols.push_back(iso14443a_pkg::SEQ_X);
            symbols.push_back(iso14443a_pkg::SEQ_Z);
        end else begin
            // end of communication is a coded 0 followed by Y
            if (prev_zero) begin
                symbols.push_back(iso14443a_pkg::SEQ_Z);
            end else begin
                symbols.push_back(iso14443a_pkg::SEQ_Y);
            end
            symbols.push_back(iso14443a_pkg::SEQ_Y);
        end

        for (b = 0; b < symbols.size(); b++) begin
            send_slot(symbols[b]);
        end
        repeat (IDLE_SLOTS) begin
            send_slot(iso14443a_pkg::SEQ_Y);
        end
    endtask

endmodule

// File: bench/rx_tb.sv
/*
 * testbench for the Type A receive path with random frames from a fixed LCG seed
 * expected events come from the frame rules and are matched in arrival order
 * the run ends as a failure if it outlasts its cycle limit
 */
`timescale 1ns/1ns
`include "iso14443a_config.svh"

module rx_tb;

    // 28 frames, none longer than 52 slots including its idle tail
    localparam int NUM_FRAMES      = 28;
    localparam int MAX_FRAME_SLOTS = 52;
    localparam int TIMEOUT_CYCLES  = (NUM_FRAMES * MAX_FRAME_SLOTS + 20) * `RX_BIT_CLOCKS;

    logic                     clk;
    logic                     rst_n;
    logic                     pause_n;
    logic                     event_seen;
    iso14443a_pkg::rx_event_t rx_event;

    iso14443a_pkg::byte_t     frame_bytes[$];
    iso14443a_pkg::rx_event_t expected_q[$];
    iso14443a_pkg::rx_event_t exp_event;
    logic [31:0]              lcg_state    = 32'h08f05436;
    logic [7:0]               data_mask;
    int                       value_errors = 0;
    int                       event_errors = 0;
    int                       cycle_count  = 0;
    int                       i;

    always #2 clk = ~clk;

    iso14443a_rx DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .pause_n  (pause_n),
        .rx_event (rx_event)
    );

    pcd_driver pcd (
        .clk     (clk),
        .pause_n (pause_n)
    );

    assign event_seen = rx_event.soc | rx_event.eoc | rx_event.sequence_error |
                        rx_event.parity_error | rx_event.data_valid;

    // ==============================
    // helpers
    // ==============================

    // the low bits of an LCG are weak, so callers get the upper ones
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    task automatic fill_random_bytes(input int count);
        logic [31:0] r;
        int          k;

        frame_bytes.delete();
        for (k = 0; k < count; k++) begin
            r = next_random();
            frame_bytes.push_back(r[7:0]);
        end
    endtask

    function automatic iso14443a_pkg::rx_event_t make_event(
        input logic soc, input logic eoc, input logic seq_err, input logic par_err,
        input logic valid, input logic [2:0] bits, input logic [7:0] data
    );
        iso14443a_pkg::rx_event_t ev;

        ev.soc            = soc;
        ev.eoc            = eoc;
        ev.sequence_error = seq_err;
        ev.parity_error   = par_err;
        ev.data_valid     = valid;
        ev.data_bits      = bits;
        ev.data           = data;
        return ev;
    endfunction

    // expected events of one frame description, straight from the frame rules
    function automatic void build_expected(
        input iso14443a_pkg::byte_t bytes[$], input int part_bits,
        input int flip_idx, input bit bad_zx, input bit trunc
    );
        int n_full;
        int k;

        n_full = bytes.size();
        if (!bad_zx && ((part_bits != 0) || trunc) && (n_full > 0)) begin
            n_full = n_full - 1;
        end
        expected_q.push_back(make_event(1, 0, 0, 0, 0, 3'd0, 8'h00));
        for (k = 0; k < n_full; k++) begin
            // a bad parity bit drops the byte and silences the rest of the frame
            if (k == flip_idx) begin
                expected_q.push_back(make_event(0, 0, 0, 1, 0, 3'd0, 8'h00));
                return;
            end
            expected_q.push_back(make_event(0, 0, 0, 0, 1, 3'd0, bytes[k]));
        end
        if (bad_zx) begin
            expected_q.push_back(make_event(0, 0, 1, 0, 0, 3'd0, 8'h00));
        end else if (trunc) begin
            expected_q.push_back(make_event(0, 1, 1, 0, 0, 3'd0, 8'h00));
        end else if (part_bits != 0) begin
            expected_q.push_back(make_event(0, 1, 0, 0, 1, part_bits[2:0],
                                            bytes[bytes.size() - 1]));
        end else begin
            expected_q.push_back(make_event(0, 1, 0, 0, 0, 3'd0, 8'h00));
        end
    endfunction

    task automatic run_frame(input int part_bits, input int flip_idx,
                             input bit bad_zx, input bit trunc);
        build_expected(frame_bytes, part_bits, flip_idx, bad_zx, trunc);
        pcd.send_frame(frame_bytes, part_bits, flip_idx, bad_zx, trunc);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic report_counts();
        $display("checks done with %0d value errors and %0d event errors",
                 value_errors, event_errors);
    endtask

    // ==============================
    // compare and watchdog
    // ==============================

    always @(posedge clk) begin
        if (rst_n !== 1'b1) begin
            // the first edge is the one that loads the reset values
            if ((cycle_count != 0) && (event_seen !== 1'b0)) begin
                $display("an event flag was not held low during reset at %0t", $time);
                event_errors++;
            end
        end else if (event_seen !== 1'b0) begin
            if (expected_q.size() == 0) begin
                $display("an event arrived with nothing left to expect at %0t", $time);
                event_errors++;
            end else begin
                exp_event = expected_q.pop_front();
                check_value("rx_event.soc", rx_event.soc, exp_event.soc);
                check_value("rx_event.eoc", rx_event.eoc, exp_event.eoc);
                check_value("rx_event.sequence_error", rx_event.sequence_error,
                            exp_event.sequence_error);
                check_value("rx_event.parity_error", rx_event.parity_error,
                            exp_event.parity_error);
                check_value("rx_event.data_valid", rx_event.data_valid, exp_event.data_valid);
                // data only counts on its low data_bits bits, 0 meaning all eight
                if (exp_event.data_valid) begin
                    check_value("rx_event.data_bits", rx_event.data_bits, exp_event.data_bits);
                    if (exp_event.data_bits == 3'd0) begin
                        data_mask = 8'hff;
                    end else begin
                        data_mask = (8'h01 << exp_event.data_bits) - 8'h01;
                    end
                    check_value("rx_event.data", rx_event.data & data_mask,
                                exp_event.data & data_mask);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            report_counts();
            $display(">>> FAIL");
            $finish;
        end
    end

    // ==============================
    // stimulus
    // ==============================

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // the line stays quiet, so no event may appear
        repeat (5 * `RX_BIT_CLOCKS) @(negedge clk);

        // full bytes with good parity
        for (i = 0; i < 8; i++) begin
            fill_random_bytes(next_random() % 4 + 1);
            run_frame(0, -1, 0, 0);
        end
        frame_bytes.delete();
        run_frame(0, -1, 0, 0);

        // short frame of 7 bits, then partial last bytes after full ones
        fill_random_bytes(1);
        run_frame(7, -1, 0, 0);
        for (i = 0; i < 4; i++) begin
            fill_random_bytes(next_random() % 3 + 1);
            run_frame(next_random() % 6 + 1, -1, 0, 0);
        end

        // each error frame is followed by a clean one
        for (i = 0; i < 3; i++) begin
            fill_random_bytes(4);
            run_frame(0, next_random() % 4, 0, 0);
            fill_random_bytes(2);
            run_frame(0, -1, 0, 0);
        end
        for (i = 0; i < 2; i++) begin
            fill_random_bytes(next_random() % 3);
            run_frame(0, -1, 1, 0);
            fill_random_bytes(2);
            run_frame(0, -1, 0, 0);
        end
        for (i = 0; i < 2; i++) begin
            fill_random_bytes(next_random() % 3 + 1);
            run_frame(0, -1, 0, 1);
            fill_random_bytes(2);
            run_frame(0, -1, 0, 0);
        end

        repeat (4 * `RX_BIT_CLOCKS) @(negedge clk);
        if (expected_q.size() != 0) begin
            $display("%0d expected events never arrived", expected_q.size());
            event_errors++;
        end
        report_counts();
        if ((value_errors == 0) && (event_errors == 0)) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+include
src/iso14443a_pkg.sv
src/miller_sequence_decoder.sv
src/frame_decode.sv
src/iso14443a_rx.sv
bench/pcd_driver.sv
bench/rx_tb.sv

// File: include/iso14443a_config.svh
/*
 * bit slot timing of the Type A receive path at 106 kbit/s
 * RX_BIT_CLOCKS must be even and at least 8 (128 at 13.56 MHz, 16 in simulation)
 * RX_IDLE_Y_SLOTS must lie between 1 and 7
 */
`ifndef ISO14443A_CONFIG_SVH
`define ISO14443A_CONFIG_SVH

// clocks per Miller bit slot, counted from the first falling edge of the frame
`define RX_BIT_CLOCKS 16

// a pause before this slot position is a Z, at or after it an X
`define RX_HALF_CLOCKS (`RX_BIT_CLOCKS / 2)

// the slot position counter runs from 0 to RX_BIT_CLOCKS - 1
`define RX_SLOT_W $clog2(`RX_BIT_CLOCKS)

// this many Y slots in a row send the sequence decoder back to idle
// the frame decoder uses the same rule to leave its error wait
`define RX_IDLE_Y_SLOTS 2

`endif

// File: src/frame_decode.sv
/*
 * turns Miller sequences into frame events, one registered cycle after seq_valid
 * the consumer must take every event in the cycle it appears
 * after a parity or sequence error nothing is reported until the line goes idle
 */
`timescale 1ns/1ns
`include "iso14443a_config.svh"

module frame_decode (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     seq_valid,
    input  iso14443a_pkg::seq_t      seq,
    output iso14443a_pkg::rx_event_t rx_event
);

    typedef enum logic [1:0] {
        IDLE,
        RX,
        ERROR_WAIT
    } state_t;

    state_t state;

    // the newest bit is held back one sequence, because a 0 followed by Y
    // is the end of communication and not data
    logic have_pend;
    logic pend_bit;

    // data bits of the current byte, 8 means the parity bit comes next
    logic [3:0]           bit_cnt;
    iso14443a_pkg::byte_t shreg;

    // xor of the data bits so far, the parity bit must make it 1
    logic par_acc;

    // run of Y sequences while waiting out an error
    logic [2:0] y_run;

    logic prev_one;
    logic bad_seq;
    logic end_seq;

    // ==============================
    // Miller rules
    // ==============================

    // after soc the previous symbol counts as a 0
    assign prev_one = have_pend && pend_bit;

    // Z straight after an X cannot be sent by a valid reader
    assign bad_seq = (seq == iso14443a_pkg::SEQ_ERR) ||
                     ((seq == iso14443a_pkg::SEQ_Z) && prev_one);

    // Y after a 0, or right after soc, closes the frame
    assign end_seq = (seq == iso14443a_pkg::SEQ_Y) && !prev_one;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state                   <= IDLE;
            have_pend               <= 1'b0;
            pend_bit                <= 1'b0;
            bit_cnt                 <= 4'd0;
            par_acc                 <= 1'b0;
            y_run                   <= 3'd0;
            rx_event.soc            <= 1'b0;
            rx_event.eoc            <= 1'b0;
            rx_event.sequence_error <= 1'b0;
            rx_event.parity_error   <= 1'b0;
            rx_event.data_valid     <= 1'b0;
        end else begin
            // every flag is a single cycle pulse
            rx_event.soc            <= 1'b0;
            rx_event.eoc            <= 1'b0;
            rx_event.sequence_error <= 1'b0;
            rx_event.parity_error   <= 1'b0;
            rx_event.data_valid     <= 1'b0;

            if (seq_valid) begin
                case (state)
                    IDLE: begin
                        // only a Z starts a frame, anything else is line noise
                        if (seq == iso14443a_pkg::SEQ_Z) begin
                            rx_event.soc <= 1'b1;
                            state        <= RX;
                            have_pend    <= 1'b0;
                            bit_cnt      <= 4'd0;
                            par_acc      <= 1'b0;
                        end
                    end

                    RX: begin
                        if (bad_seq) begin
                            rx_event.sequence_error <= 1'b1;
                            state                   <= ERROR_WAIT;
                            y_run                   <= 3'd0;
                        end else if (end_seq) begin
                            // the held 0 belongs to the end of communication
                            rx_event.eoc <= 1'b1;
                            state        <= IDLE;
                            have_pend    <= 1'b0;
                            if (bit_cnt == 4'd8) begin
                                // the frame stopped where its parity bit should be
                                rx_event.sequence_error <= 1'b1;
                            end else if (bit_cnt != 4'd0) begin
                                rx_event.data_valid <= 1'b1;
                                rx_event.data_bits  <= bit_cnt[2:0];
                                rx_event.data       <= shreg;
                            end
                        end else begin
                            // X is a 1, Y after X and Z after a 0 are both 0
                            have_pend <= 1'b1;
                            pend_bit  <= (seq == iso14443a_pkg::SEQ_X);

                            // the bit held back so far is now known to be data
                            if (have_pend) begin
                                if (bit_cnt == 4'd8) begin
                                    bit_cnt <= 4'd0;
                                    par_acc <= 1'b0;
                                    if (par_acc ^ pend_bit) begin
                                        rx_event.data_valid <= 1'b1;
                                        rx_event.data_bits  <= '0;
                                        rx_event.data       <= shreg;
                                    end else begin
                                        // byte is dropped, and this Y may already
                                        // count toward the idle line
                                        rx_event.parity_error <= 1'b1;
                                        state                 <= ERROR_WAIT;
                                        if (seq == iso14443a_pkg::SEQ_Y) begin
                                            y_run <= 3'd1;
                                        end else begin
                                            y_run <= 3'd0;
                                        end
                                    end
                                end else begin
                                    shreg[bit_cnt[2:0]] <= pend_bit;
                                    par_acc             <= par_acc ^ pend_bit;
                                    bit_cnt             <= bit_cnt + 4'd1;
                                end
                            end
                        end
                    end

                    ERROR_WAIT: begin
                        // the same Y run that idles the sequence decoder ends the wait
                        if (seq == iso14443a_pkg::SEQ_Y) begin
                            y_run <= y_run + 3'd1;
                            if (y_run + 3'd1 == `RX_IDLE_Y_SLOTS) begin
                                state <= IDLE;
                            end
                        end else begin
                            y_run <= 3'd0;
                        end
                    end

                    default: begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

    // ==============================
    // assertions
    // ==============================

    // sequences are a full slot apart, so no event can repeat on the next cycle
    event_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rx_event.soc || rx_event.eoc || rx_event.sequence_error ||
         rx_event.parity_error || rx_event.data_valid)
        |=> !(rx_event.soc || rx_event.eoc || rx_event.sequence_error ||
              rx_event.parity_error || rx_event.data_valid)
    ) else $error("frame event held for more than one cycle");

    soc_alone: assert property (
        @(posedge clk) disable iff (!rst_n)
        rx_event.soc |-> !(rx_event.eoc || rx_event.sequence_error ||
                           rx_event.parity_error || rx_event.data_valid)
    ) else $error("soc raised together with another flag");

    // a partial byte is only ever delivered at the end of the frame
    partial_byte_at_eoc: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rx_event.data_valid && (rx_event.data_bits != '0)) |-> rx_event.eoc
    ) else $error("partial byte delivered without eoc");

endmodule

// File: src/iso14443a_pkg.sv
/*
 * shared types of the Type A receive path
 * rx_event_t keeps the field order of the frame decoder event interface
 * data and data_bits only mean something while data_valid is high
 */

package iso14443a_pkg;

    // ==============================
    // Miller sequences
    // ==============================

    // X has its pause in the second half, Z in the first, Y has none
    // SEQ_ERR marks a slot that held more than one pause
    typedef enum logic [1:0] {
        SEQ_X   = 2'd0,
        SEQ_Y   = 2'd1,
        SEQ_Z   = 2'd2,
        SEQ_ERR = 2'd3
    } seq_t;

    // ==============================
    // frame events
    // ==============================

    // one received byte, least significant bit first on the air
    typedef logic [7:0] byte_t;

    // valid bits of a partial byte, 0 stands for a full byte
    typedef logic [2:0] bit_count_t;

    // soc is always alone and parity_error is always alone
    // sequence_error only joins eoc when the frame stops before a parity bit
    // data_valid joins eoc only for a partial last byte
    typedef struct packed {
        logic       soc;
        logic       eoc;
        logic       sequence_error;
        logic       parity_error;
        logic       data_valid;
        bit_count_t data_bits;
        byte_t      data;
    } rx_event_t;

endpackage

// File: src/iso14443a_rx.sv
/*
 * reader to card receive path of an ISO/IEC 14443 Type A card at 106 kbit/s
 * pause_n is low during a field pause and must already be synchronous to clk
 * an event appears RX_BIT_CLOCKS + 1 cycles after the start of the slot that completes it
 * there is no back pressure on rx_event
 */
`timescale 1ns/1ns

module iso14443a_rx (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pause_n,
    output iso14443a_pkg::rx_event_t rx_event
);

    // ==============================
    // sequence stream
    // ==============================

    // one strobe per bit slot, consumed by the frame decoder in the same cycle
    logic                seq_valid;
    iso14443a_pkg::seq_t seq;

    miller_sequence_decoder u_miller (
        .clk       (clk),
        .rst_n     (rst_n),
        .pause_n   (pause_n),
        .seq_valid (seq_valid),
        .seq       (seq)
    );

    // ==============================
    // frame events
    // ==============================

    frame_decode u_frame (
        .clk       (clk),
        .rst_n     (rst_n),
        .seq_valid (seq_valid),
        .seq       (seq),
        .rx_event  (rx_event)
    );

endmodule

// File: src/miller_sequence_decoder.sv
/*
 * cuts the pause signal into Miller bit slots and classifies each one
 * pause_n must already be synchronous to clk and a pause must last at least one cycle
 * seq_valid pulses exactly RX_BIT_CLOCKS cycles after the start of each slot
 */
`timescale 1ns/1ns
`include "iso14443a_config.svh"

module miller_sequence_decoder (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pause_n,
    output logic                seq_valid,
    output iso14443a_pkg::seq_t seq
);

    typedef enum logic {
        IDLE,
        IN_FRAME
    } state_t;

    // slot positions as plain numbers, sliced down to the counter width below
    localparam int unsigned LAST_POS = `RX_BIT_CLOCKS - 1;
    localparam int unsigned HALF_POS = `RX_HALF_CLOCKS;

    state_t state;

    // previous sample of pause_n, used to find the start of a pause
    logic pause_q;
    logic fall;

    // position inside the slot of the sample taken at the current edge
    logic [`RX_SLOT_W-1:0] pos;

    // pauses seen so far in the open slot
    logic first_half;
    logic second_half;
    logic double_pause;

    // run of Y slots that have just been emitted
    logic [2:0] y_run;

    logic                in_first;
    logic                slot_end;
    iso14443a_pkg::seq_t slot_seq;

    // ==============================
    // edge detection and slot tracking
    // ==============================

    assign fall     = pause_q && !pause_n;
    assign in_first = (pos < HALF_POS[`RX_SLOT_W-1:0]);

    // position 0 while in a frame closes the previous slot and opens the next
    assign slot_end = (state == IN_FRAME) && (pos == '0);

    // two pauses in one slot win over everything else
    always_comb begin
        if (double_pause) begin
            slot_seq = iso14443a_pkg::SEQ_ERR;
        end else if (first_half) begin
            slot_seq = iso14443a_pkg::SEQ_Z;
        end else if (second_half) begin
            slot_seq = iso14443a_pkg::SEQ_X;
        end else begin
            slot_seq = iso14443a_pkg::SEQ_Y;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= IDLE;
            pause_q      <= 1'b1;
            pos          <= '0;
            first_half   <= 1'b0;
            second_half  <= 1'b0;
            double_pause <= 1'b0;
            y_run        <= 3'd0;
            seq_valid    <= 1'b0;
        end else begin
            pause_q   <= pause_n;
            seq_valid <= 1'b0;

            case (state)
                IDLE: begin
                    // the first pause of a frame sits at position 0, so the slot is a Z
                    if (fall) begin
                        state        <= IN_FRAME;
                        pos          <= {{(`RX_SLOT_W - 1){1'b0}}, 1'b1};
                        first_half   <= 1'b1;
                        second_half  <= 1'b0;
                        double_pause <= 1'b0;
                        y_run        <= 3'd0;
                    end
                end

                IN_FRAME: begin
                    if (pos == LAST_POS[`RX_SLOT_W-1:0]) begin
                        pos <= '0;
                    end else begin
                        pos <= pos + 1'b1;
                    end

                    if (slot_end) begin
                        seq_valid <= 1'b1;

                        // a pause sampled right on the boundary opens the new slot
                        first_half   <= fall;
                        second_half  <= 1'b0;
                        double_pause <= 1'b0;

                        if (slot_seq == iso14443a_pkg::SEQ_Y) begin
                            y_run <= y_run + 3'd1;
                            // stay in the frame if a new pause already started this slot
                            if ((y_run + 3'd1 == `RX_IDLE_Y_SLOTS) && !fall) begin
                                state <= IDLE;
                            end
                        end else begin
                            y_run <= 3'd0;
                        end
                    end else if (fall) begin
                        if (first_half || second_half) begin
                            double_pause <= 1'b1;
                        end
                        if (in_first) begin
                            first_half <= 1'b1;
                        end else begin
                            second_half <= 1'b1;
                        end
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // the sequence itself only matters while seq_valid is high
    always_ff @(posedge clk) begin
        if (slot_end) begin
            seq <= slot_seq;
        end
    end

    // ==============================
    // assertions
    // ==============================

    // slots are RX_BIT_CLOCKS apart, so the strobe never lasts two cycles
    seq_valid_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        seq_valid |=> !seq_valid
    ) else $error("seq_valid held for more than one cycle");

    // an idle decoder has no open slot to report
    no_seq_from_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == IDLE) |=> !seq_valid
    ) else $error("seq_valid raised from IDLE");

endmodule
